// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = phy_rx_tb
FILELIST  = sim.f
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== design/crc32_unrolled.sv ====
`timescale 1ns/1ps

module crc32_unrolled #(
    parameter int UNROLL_FACTOR = 8
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        crc_clear,
    input  logic        crc_update,
    input  logic [31:0] data,
    output logic [31:0] crc_value,
    output logic        crc_done,
    output logic        busy
);

    localparam int STEPS = 32 / UNROLL_FACTOR;
    localparam int STEP_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic [31:0]       crc_q, crc_next;
    logic [31:0]       shift_q, fold_in;
    logic [STEP_W-1:0] step_q;
    logic              busy_q, done_q;

    // the first slice is folded straight from the input on the load edge
    assign fold_in = busy_q ? shift_q : data;

    always_comb begin
        logic fb;
        crc_next = crc_q;
        for (int i = 0; i < UNROLL_FACTOR; i++) begin
            fb = crc_next[31] ^ fold_in[31-i];
            crc_next = {crc_next[30:0], 1'b0} ^ (fb ? phy_rx_pkg::CRC_POLY : 32'h0);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            crc_q <= phy_rx_pkg::CRC_INIT;
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else if (crc_clear) begin
            crc_q <= phy_rx_pkg::CRC_INIT; // also drops a fold in flight
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (crc_update) begin
                crc_q <= crc_next;
                step_q <= STEP_W'(1);
                busy_q <= (STEPS > 1);
                done_q <= (STEPS == 1);
            end else if (busy_q) begin
                crc_q <= crc_next;
                step_q <= step_q + 1'b1;
                if (step_q == STEP_W'(STEPS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (crc_update) begin
            shift_q <= data << UNROLL_FACTOR;
        end else if (busy_q) begin
            shift_q <= shift_q << UNROLL_FACTOR;
        end
    end

    assign crc_value = crc_q;
    assign crc_done = done_q;
    assign busy = busy_q;

    assert property (@(posedge CLK) disable iff (!nRST) crc_update |-> !busy_q);

endmodule

// ==== design/dec_8b10b.sv ====
`timescale 1ns/1ps

module dec_8b10b (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic [phy_rx_pkg::SYM_W*phy_rx_pkg::SYMS_PER_FLIT-1:0] enc_flit,
    input  logic                                                flit_strobe,
    input  logic                                                line_err,
    output phy_rx_pkg::flit_t                                   word,
    output logic                                                word_valid,
    output logic                                                is_comma,
    output logic                                                code_err
);

    localparam int SYM_W = phy_rx_pkg::SYM_W;
    localparam int SYMS = phy_rx_pkg::SYMS_PER_FLIT;

    logic [8*SYMS-1:0] dec_word;
    logic              dec_err;
    logic              first_comma;

    // returns {err, EDCBA}, both disparities accepted
    function automatic logic [5:0] dec_6b(input logic [5:0] code);
        logic [5:0] res;
        res = 6'd0;
        case (code)
            6'b100111, 6'b011000: res[4:0] = 5'd0;
            6'b011101, 6'b100010: res[4:0] = 5'd1;
            6'b101101, 6'b010010: res[4:0] = 5'd2;
            6'b110001:            res[4:0] = 5'd3;
            6'b110101, 6'b001010: res[4:0] = 5'd4;
            6'b101001:            res[4:0] = 5'd5;
            6'b011001:            res[4:0] = 5'd6;
            6'b111000, 6'b000111: res[4:0] = 5'd7;
            6'b111001, 6'b000110: res[4:0] = 5'd8;
            6'b100101:            res[4:0] = 5'd9;
            6'b010101:            res[4:0] = 5'd10;
            6'b110100:            res[4:0] = 5'd11;
            6'b001101:            res[4:0] = 5'd12;
            6'b101100:            res[4:0] = 5'd13;
            6'b011100:            res[4:0] = 5'd14;
            6'b010111, 6'b101000: res[4:0] = 5'd15;
            6'b011011, 6'b100100: res[4:0] = 5'd16;
            6'b100011:            res[4:0] = 5'd17;
            6'b010011:            res[4:0] = 5'd18;
            6'b110010:            res[4:0] = 5'd19;
            6'b001011:            res[4:0] = 5'd20;
            6'b101010:            res[4:0] = 5'd21;
            6'b011010:            res[4:0] = 5'd22;
            6'b111010, 6'b000101: res[4:0] = 5'd23;
            6'b110011, 6'b001100: res[4:0] = 5'd24;
            6'b100110:            res[4:0] = 5'd25;
            6'b010110:            res[4:0] = 5'd26;
            6'b110110, 6'b001001: res[4:0] = 5'd27;
            6'b001110:            res[4:0] = 5'd28;
            6'b101110, 6'b010001: res[4:0] = 5'd29;
            6'b011110, 6'b100001: res[4:0] = 5'd30;
            6'b101011, 6'b010100: res[4:0] = 5'd31;
            default:              res[5] = 1'b1; // K28 sub-block only valid inside a comma
        endcase
        return res;
    endfunction

    // returns {err, HGF}
    function automatic logic [3:0] dec_4b(input logic [3:0] code);
        logic [3:0] res;
        res = 4'd0;
        case (code)
            4'b1011, 4'b0100: res[2:0] = 3'd0;
            4'b1001:          res[2:0] = 3'd1;
            4'b0101:          res[2:0] = 3'd2;
            4'b1100, 4'b0011: res[2:0] = 3'd3;
            4'b1101, 4'b0010: res[2:0] = 3'd4;
            4'b1010:          res[2:0] = 3'd5;
            4'b0110:          res[2:0] = 3'd6;
            4'b1110, 4'b0001,
            4'b0111, 4'b1000: res[2:0] = 3'd7; // primary and alternate D.x.7
            default:          res[3] = 1'b1;
        endcase
        return res;
    endfunction

    function automatic logic [8:0] dec_sym(input logic [SYM_W-1:0] sym);
        logic [5:0] lo;
        logic [3:0] hi;
        lo = dec_6b(sym[9:4]);
        hi = dec_4b(sym[3:0]);
        if (sym == phy_rx_pkg::K28_5_RDN || sym == phy_rx_pkg::K28_5_RDP) begin
            return {1'b0, 8'hBC};
        end
        return {lo[5] | hi[3], hi[2:0], lo[4:0]};
    endfunction

    // symbol 0 sits in the top bits and lands in the top byte
    always_comb begin
        logic [8:0] sym_res;
        dec_word = '0;
        dec_err = line_err;
        for (int s = 0; s < SYMS; s++) begin
            sym_res = dec_sym(enc_flit[(SYMS-1-s)*SYM_W +: SYM_W]);
            dec_word[(SYMS-1-s)*8 +: 8] = sym_res[7:0];
            dec_err = dec_err | sym_res[8];
        end
    end

    assign first_comma = (enc_flit[SYMS*SYM_W-1 -: SYM_W] == phy_rx_pkg::K28_5_RDN) ||
                         (enc_flit[SYMS*SYM_W-1 -: SYM_W] == phy_rx_pkg::K28_5_RDP);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            word_valid <= 1'b0;
            is_comma <= 1'b0;
            code_err <= 1'b0;
        end else begin
            word_valid <= flit_strobe;
            is_comma <= flit_strobe && first_comma && !dec_err; // a bad comma is just an error
            code_err <= flit_strobe && dec_err;
        end
    end

    always_ff @(posedge CLK) begin
        if (flit_strobe) begin
            word <= dec_word; // held until the next strobe
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(is_comma && code_err));

endmodule

// ==== design/packet_tracker.sv ====
`timescale 1ns/1ps

module packet_tracker #(
    parameter int CNT_BITS = 8
) (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              accept,
    input  logic              tracker_clear,
    input  phy_rx_pkg::flit_t word,
    output logic              is_header,
    output logic              is_last_payload,
    output logic              is_crc_word
);

    logic                expect_hdr_q;
    logic [CNT_BITS-1:0] size_q;
    logic [CNT_BITS-1:0] count_q; // payload words taken so far

    assign is_header = expect_hdr_q;
    assign is_crc_word = !expect_hdr_q && (count_q == size_q);
    assign is_last_payload = !expect_hdr_q && (size_q != '0) && (count_q == size_q - 1'b1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            expect_hdr_q <= 1'b1;
            size_q <= '0;
            count_q <= '0;
        end else if (tracker_clear) begin
            expect_hdr_q <= 1'b1;
            count_q <= '0;
        end else if (accept) begin
            if (expect_hdr_q) begin
                size_q <= CNT_BITS'(word.hdr.size);
                count_q <= '0;
                expect_hdr_q <= 1'b0;
            end else if (is_crc_word) begin
                expect_hdr_q <= 1'b1; // packet closed
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) !(is_header && is_crc_word));

endmodule

// ==== design/phy_rx_pkg.sv ====
package phy_rx_pkg;

    localparam int SYM_W = 10;
    localparam int SYMS_PER_FLIT = 4;

    // symbols are written abcdei_fghj with bit a in the msb
    localparam logic [SYM_W-1:0] K28_5_RDN = 10'b001111_1010;
    localparam logic [SYM_W-1:0] K28_5_RDP = 10'b110000_0101;

    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7; // msb first, no reflection
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF; // no final inversion

    // a decoded word is a header or a plain data word
    typedef union packed {
        struct packed {
            logic [3:0]  format;
            logic [7:0]  size;     // number of payload flits that follow
            logic [19:0] rsvd;
        } hdr;
        logic [31:0] payload;
    } flit_t;

endpackage

// ==== design/phy_rx_top.sv ====
`timescale 1ns/1ps

module phy_rx_top #(
    parameter int UNROLL_FACTOR = 8,
    parameter int CNT_BITS = 8
) (
    input  logic                                                CLK,
    input  logic                                                nRST,
    input  logic [phy_rx_pkg::SYM_W*phy_rx_pkg::SYMS_PER_FLIT-1:0] enc_flit,
    input  logic                                                flit_strobe,
    input  logic                                                line_err,
    output phy_rx_pkg::flit_t                                   flit,
    output logic                                                flit_valid,
    output logic                                                comma_seen,
    output logic                                                packet_done,
    output logic                                                crc_ok,
    output logic                                                err_out
);

    phy_rx_pkg::flit_t dec_word;
    logic              dec_valid, dec_comma, dec_err;
    logic              accept, tracker_clear;
    logic              is_header, is_crc_word;
    logic              crc_clear, crc_update, crc_done, crc_busy;
    logic [31:0]       crc_value;

    dec_8b10b dec_i (
        .CLK(CLK),
        .nRST(nRST),
        .enc_flit(enc_flit),
        .flit_strobe(flit_strobe),
        .line_err(line_err),
        .word(dec_word),
        .word_valid(dec_valid),
        .is_comma(dec_comma),
        .code_err(dec_err)
    );

    crc32_unrolled #(
        .UNROLL_FACTOR(UNROLL_FACTOR)
    ) crc_i (
        .CLK(CLK),
        .nRST(nRST),
        .crc_clear(crc_clear),
        .crc_update(crc_update),
        .data(dec_word.payload),
        .crc_value(crc_value),
        .crc_done(crc_done),
        .busy(crc_busy)
    );

    packet_tracker #(
        .CNT_BITS(CNT_BITS)
    ) trk_i (
        .CLK(CLK),
        .nRST(nRST),
        .accept(accept),
        .tracker_clear(tracker_clear),
        .word(dec_word),
        .is_header(is_header),
        .is_last_payload(),
        .is_crc_word(is_crc_word)
    );

    rx_manager #(
        .UNROLL_FACTOR(UNROLL_FACTOR)
    ) mgr_i (
        .CLK(CLK),
        .nRST(nRST),
        .word(dec_word),
        .word_valid(dec_valid),
        .is_comma(dec_comma),
        .code_err(dec_err),
        .is_header(is_header),
        .is_crc_word(is_crc_word),
        .crc_value(crc_value),
        .crc_done(crc_done),
        .crc_busy(crc_busy),
        .crc_clear(crc_clear),
        .crc_update(crc_update),
        .accept(accept),
        .tracker_clear(tracker_clear),
        .flit_valid(flit_valid),
        .comma_seen(comma_seen),
        .packet_done(packet_done),
        .crc_ok(crc_ok),
        .err_out(err_out)
    );

    assign flit = dec_word;

endmodule

// ==== design/rx_manager.sv ====
`timescale 1ns/1ps

module rx_manager #(
    parameter int UNROLL_FACTOR = 8
) (
    input  logic              CLK,
    input  logic              nRST,
    input  phy_rx_pkg::flit_t word,
    input  logic              word_valid,
    input  logic              is_comma,
    input  logic              code_err,
    input  logic              is_header,
    input  logic              is_crc_word,
    input  logic [31:0]       crc_value,
    input  logic              crc_done,
    input  logic              crc_busy,
    output logic              crc_clear,
    output logic              crc_update,
    output logic              accept,
    output logic              tracker_clear,
    output logic              flit_valid,
    output logic              comma_seen,
    output logic              packet_done,
    output logic              crc_ok,
    output logic              err_out
);

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] FOLD  = 2'd1;
    localparam logic [1:0] CHECK = 2'd2;
    localparam logic [1:0] ERR   = 2'd3;

    localparam int MIN_GAP = 32 / UNROLL_FACTOR + 1; // quiet cycles needed after each word

    logic [1:0] state_q, state_d;
    logic       fold_payload_q; // the word in the CRC engine is payload, not header
    logic       overrun, bad_word, take_word;
    logic       err_pulse_q, comma_pulse_q;

    assign overrun = word_valid && (crc_busy || state_q == FOLD);
    assign bad_word = (word_valid && code_err) || overrun;
    assign take_word = (state_q == IDLE) && word_valid && !is_comma && !bad_word;

    always_comb begin
        state_d = state_q;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        accept = 1'b0;
        tracker_clear = 1'b0;
        flit_valid = 1'b0;
        packet_done = 1'b0;
        crc_ok = 1'b0;
        case (state_q)
            IDLE: begin
                if (take_word) begin
                    accept = 1'b1;
                    if (is_crc_word) begin
                        state_d = CHECK;
                    end else begin
                        crc_update = 1'b1;
                        state_d = FOLD;
                    end
                end
            end
            FOLD: begin
                if (crc_done) begin
                    flit_valid = fold_payload_q;
                    state_d = IDLE;
                end
            end
            CHECK: begin
                packet_done = 1'b1;
                crc_ok = (crc_value == word.payload); // word still holds the CRC flit
                crc_clear = 1'b1;
                tracker_clear = 1'b1;
                state_d = IDLE;
            end
            default: begin
                crc_clear = 1'b1;
                tracker_clear = 1'b1;
                if (word_valid && is_comma) begin
                    state_d = IDLE; // next word starts a new packet
                end
            end
        endcase
        if (bad_word && state_q != ERR) begin
            state_d = ERR;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q <= IDLE;
            fold_payload_q <= 1'b0;
            err_pulse_q <= 1'b0;
            comma_pulse_q <= 1'b0;
        end else begin
            state_q <= state_d;
            err_pulse_q <= bad_word && (state_q != ERR); // once per error burst
            comma_pulse_q <= word_valid && is_comma;
            if (crc_update) begin
                fold_payload_q <= !is_header;
            end
        end
    end

    assign err_out = err_pulse_q;
    assign comma_seen = comma_pulse_q;

    // the source keeps strobes at least 32/UNROLL_FACTOR + 2 cycles apart
    for (genvar k = 1; k <= MIN_GAP; k++) begin : g_gap
        assert property (@(posedge CLK) disable iff (!nRST)
            word_valid |-> !$past(word_valid, k));
    end

endmodule

// ==== sim.f ====
design/phy_rx_pkg.sv
design/dec_8b10b.sv
design/crc32_unrolled.sv
design/packet_tracker.sv
design/rx_manager.sv
design/phy_rx_top.sv
testbench/phy_rx_tb.sv

// ==== testbench/phy_rx_stimulus.txt ====
# columns are enc_flit line_err word comma_seen flit_valid packet_done crc_ok err_out
# symbol 0 sits in the top ten bits of enc_flit and decodes to the top byte of word
3EB053EB05 0 BCBCBCBC 1 0 0 0 0
6FAB9AFABE 0 F03FFFFF 0 0 0 0 0
AF2ABD6DD9 0 7F150421 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 0 1 1 0
6FAB9AFABE 0 F03FFFFF 0 0 0 0 0
AF2ABD6DD9 0 7F150421 0 1 0 0 0
9EE7B9EDDB 0 00000001 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 0 1 0 0
6FAB9AFABE 0 F03FFFFF 0 0 0 0 0
FEE7B9EE7B 0 00000000 0 0 0 0 1
9EE7B9EE7B 0 00000000 0 0 0 0 0
9EE7B9EE7B 0 00000000 0 0 0 0 0
3EB053EB05 0 BCBCBCBC 1 0 0 0 0
6FAB9AFABE 0 F03FFFFF 0 0 0 0 0
AF2ABD6DD9 0 7F150421 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 1 0 0 0
9EE7B9EE7B 0 00000000 0 0 1 1 0
6F97BAFABE 1 F00FFFFF 0 0 0 0 1
AF2ABD6DD9 0 7F150421 0 0 0 0 0
3EB053EB05 0 BCBCBCBC 1 0 0 0 0
6F97BAFABE 0 F00FFFFF 0 0 0 0 0
9955D3963A 0 598A5CB1 0 0 1 1 0
3EB053EB05 0 BCBCBCBC 1 0 0 0 0

// ==== testbench/phy_rx_tb.sv ====
`timescale 1ns/1ps

module phy_rx_tb;

    localparam int ENC_W = phy_rx_pkg::SYM_W * phy_rx_pkg::SYMS_PER_FLIT;
    localparam int WINDOW = 8; // cycles from one strobe to the next
    localparam string STIM_FILE = "testbench/phy_rx_stimulus.txt";

    logic              CLK;
    logic              nRST;
    logic [ENC_W-1:0]  enc_flit;
    logic              flit_strobe;
    logic              line_err;
    phy_rx_pkg::flit_t flit;
    logic              flit_valid;
    logic              comma_seen;
    logic              packet_done;
    logic              crc_ok;
    logic              err_out;

    logic [ENC_W-1:0] enc_q[$];
    logic             lerr_q[$];
    logic [31:0]      word_q[$];
    logic [4:0]       flags_q[$]; // {comma, flit_valid, packet_done, crc_ok, err_out}

    int cycle_cnt = 0;
    int cycle_limit = 0; // stays 0 until the vectors are loaded

    phy_rx_top dut_i (
        .CLK(CLK),
        .nRST(nRST),
        .enc_flit(enc_flit),
        .flit_strobe(flit_strobe),
        .line_err(line_err),
        .flit(flit),
        .flit_valid(flit_valid),
        .comma_seen(comma_seen),
        .packet_done(packet_done),
        .crc_ok(crc_ok),
        .err_out(err_out)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles before all vectors were applied", cycle_limit);
            $display("CHECKS FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_vectors();
        int               fd;
        int               n;
        string            line;
        logic [ENC_W-1:0] enc;
        logic [31:0]      lerr, word, c, v, d, o, e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            $display("CHECKS FAILED");
            $fatal(1, "no stimulus file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h", enc, lerr, word, c, v, d, o, e);
                    if (n != 8) begin
                        $display("malformed stimulus line: %s", line);
                        $display("CHECKS FAILED");
                        $fatal(1, "bad stimulus file");
                    end else begin
                        enc_q.push_back(enc);
                        lerr_q.push_back(lerr[0]);
                        word_q.push_back(word);
                        flags_q.push_back({c[0], v[0], d[0], o[0], e[0]});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // starts on a rising edge and returns on the rising edge of the next strobe slot
    task automatic run_vector(input int idx);
        logic        seen_comma, seen_valid, seen_done, seen_ok, seen_err;
        logic [31:0] valid_word;
        logic [31:0] last_flit;
        logic [4:0]  exp;
        seen_comma = 1'b0;
        seen_valid = 1'b0;
        seen_done = 1'b0;
        seen_ok = 1'b0;
        seen_err = 1'b0;
        valid_word = '0;
        last_flit = '0;
        exp = flags_q[idx];
        flit_strobe <= 1'b1;
        enc_flit <= enc_q[idx];
        line_err <= lerr_q[idx];
        for (int k = 0; k < WINDOW; k++) begin
            @(negedge CLK);
            seen_comma = seen_comma | comma_seen;
            seen_err = seen_err | err_out;
            if (flit_valid) begin
                seen_valid = 1'b1;
                valid_word = flit.payload;
            end
            if (packet_done) begin
                seen_done = 1'b1;
                seen_ok = crc_ok; // crc_ok only counts alongside packet_done
            end
            last_flit = flit.payload;
            @(posedge CLK);
            if (k == 0) begin
                flit_strobe <= 1'b0;
                line_err <= 1'b0;
            end
        end
        check_value($sformatf("comma_seen (vector %0d)", idx), 32'(seen_comma), 32'(exp[4]));
        check_value($sformatf("flit_valid (vector %0d)", idx), 32'(seen_valid), 32'(exp[3]));
        check_value($sformatf("packet_done (vector %0d)", idx), 32'(seen_done), 32'(exp[2]));
        check_value($sformatf("crc_ok (vector %0d)", idx), 32'(seen_ok), 32'(exp[1]));
        check_value($sformatf("err_out (vector %0d)", idx), 32'(seen_err), 32'(exp[0]));
        if (!exp[0] || lerr_q[idx]) begin // only an invalid symbol leaves the data undefined
            check_value($sformatf("flit (vector %0d)", idx), last_flit, word_q[idx]);
        end
        if (exp[3]) begin
            check_value($sformatf("flit at flit_valid (vector %0d)", idx), valid_word,
                        word_q[idx]);
        end
    endtask

    initial begin
        nRST = 1'b0;
        enc_flit = '0;
        flit_strobe = 1'b0;
        line_err = 1'b0;
        load_vectors();
        cycle_limit = (enc_q.size() + 4) * WINDOW;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        for (int i = 0; i < enc_q.size(); i++) begin
            run_vector(i);
        end
        if (enc_q.size() == 0) begin
            $display("the stimulus file holds no vectors");
            $display("CHECKS FAILED");
            $fatal(1, "nothing was tested");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
